//--- verilog/usbRxPkg.sv
package usbRxPkg;

    // One received byte
    typedef logic [7:0] byte_t;

    // Differential line sample, already in the 12 MHz domain
    typedef struct packed {
        // D+ level
        logic dp;
        // Pair was a proper J or K
        logic valid;
        // End of packet seen on the line
        logic eop;
    } lineSample_t;

    // PID byte as it comes off the wire, LSB first
    typedef struct packed {
        // Ones complement of the type nibble
        logic [3:0] check;
        // Low two bits give the packet kind
        logic [3:0] pidType;
    } pidFields_t;

    // First byte after sync is a PID, everything later is data
    typedef union packed {
        byte_t raw;
        pidFields_t pid;
    } rxByte_u;

    // Packet kind from PID bits [1:0]
    typedef enum logic [1:0] {
        KIND_SPECIAL   = 2'b00,
        KIND_TOKEN     = 2'b01,
        KIND_HANDSHAKE = 2'b10,
        KIND_DATA      = 2'b11
    } pktKind_e;

    // Assembled byte leaving the deserializer
    typedef struct packed {
        rxByte_u data;
        logic isPid;
    } rxWord_t;

    // Decoded sync, LSB first: seven zeros then a one
    localparam byte_t SYNC_PATTERN = 8'h80;

    // Ones in a row before a zero is stuffed
    localparam int STUFF_RUN = 6;

    // Serial CRC polynomials, MSB term implied
    localparam logic [4:0] CRC5_POLY = 5'b00101;
    localparam logic [15:0] CRC16_POLY = 16'h8005;

    // Remainders left behind by a correct packet
    localparam logic [4:0] CRC5_RESIDUAL = 5'b01100;
    localparam logic [15:0] CRC16_RESIDUAL = 16'h800D;

endpackage

//--- verilog/nrziUnstuff.sv
`timescale 1ns/1ns

module nrziUnstuff import usbRxPkg::*; (
    input  logic        clk12_i,
    input  logic        rstN_i,
    input  lineSample_t sample_i,
    input  logic        restart_i,
    output logic        bitValid_o,
    output logic        bitData_o,
    output logic        stuffError_o,
    output logic        lineError_o
);

    // Line level of the previous sample
    logic prevDp;
    // Consecutive decoded ones
    logic [2:0] onesRun;
    logic decoded;
    logic stuffSlot;

    // No change on the line means a one
    assign decoded = (sample_i.dp == prevDp);

    // Bit after a full run of ones is the stuffed zero
    assign stuffSlot = (onesRun == 3'(STUFF_RUN));

    // Run counter and previous level, back to J on restart
    always_ff @(posedge clk12_i) begin
        if (!rstN_i || restart_i) begin
            prevDp <= 1'b1;
            onesRun <= '0;
        end else begin
            prevDp <= sample_i.dp;
            if (stuffSlot || !decoded) begin
                onesRun <= '0;
            end else begin
                onesRun <= onesRun + 3'd1;
            end
        end
    end

    // Flags registered so they line up with the decoded bit
    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            bitValid_o <= 1'b0;
            stuffError_o <= 1'b0;
            lineError_o <= 1'b0;
        end else begin
            bitValid_o <= !stuffSlot;
            // A one where the stuffed zero belongs
            stuffError_o <= stuffSlot && decoded;
            lineError_o <= !sample_i.valid;
        end
    end

    always_ff @(posedge clk12_i) begin
        bitData_o <= decoded;
    end

endmodule

//--- verilog/byteDeserializer.sv
`timescale 1ns/1ns

module byteDeserializer import usbRxPkg::*; (
    input  logic    clk12_i,
    input  logic    rstN_i,
    input  logic    bitValid_i,
    input  logic    bitData_i,
    input  logic    hunt_i,
    input  logic    clear_i,
    output rxWord_t word_o,
    output logic    wordStrobe_o,
    output logic    syncSeen_o
);

    byte_t shiftReg;
    byte_t shiftNext;
    logic [2:0] bitCount;
    // Set by the sync match, bytes are counted from here on
    logic inPacket;
    // Next completed byte is the PID
    logic firstWord;
    logic hunting;
    logic shiftEn;
    logic byteDone;

    assign hunting = hunt_i && !inPacket;

    // While hunting every line bit is taken, so a stuff slot left over
    // from idle cannot swallow a sync zero
    assign shiftEn = bitValid_i || hunting;

    // LSB first, new bit enters at the top
    assign shiftNext = {bitData_i, shiftReg[7:1]};
    assign byteDone = inPacket && bitValid_i && (bitCount == 3'd7);

    // Clear fills with idle ones so old bits cannot form a sync
    always_ff @(posedge clk12_i) begin
        if (!rstN_i || clear_i) begin
            shiftReg <= '1;
        end else if (shiftEn) begin
            shiftReg <= shiftNext;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (!rstN_i || clear_i) begin
            inPacket <= 1'b0;
            bitCount <= '0;
            firstWord <= 1'b0;
            wordStrobe_o <= 1'b0;
            syncSeen_o <= 1'b0;
        end else begin
            wordStrobe_o <= byteDone;
            syncSeen_o <= 1'b0;
            if (hunting) begin
                if (shiftNext == SYNC_PATTERN) begin
                    inPacket <= 1'b1;
                    bitCount <= '0;
                    firstWord <= 1'b1;
                    syncSeen_o <= 1'b1;
                end
            end else if (inPacket && bitValid_i) begin
                bitCount <= bitCount + 3'd1;
                if (byteDone) begin
                    firstWord <= 1'b0;
                end
            end
        end
    end

    // Completed byte, held until the next one
    always_ff @(posedge clk12_i) begin
        if (byteDone) begin
            word_o.data.raw <= shiftNext;
            word_o.isPid <= firstWord;
        end
    end

endmodule

//--- verilog/crcCheck.sv
`timescale 1ns/1ns

module crcCheck import usbRxPkg::*; (
    input  logic clk12_i,
    input  logic rstN_i,
    input  logic clear_i,
    input  logic use16_i,
    input  logic bitValid_i,
    input  logic bitData_i,
    output logic crcGood_o
);

    // CRC5 lives in the low five bits
    logic [15:0] crcReg;
    logic feedback;

    // Feedback taps the top bit of the active width
    assign feedback = bitData_i ^ (use16_i ? crcReg[15] : crcReg[4]);

    // Serial LFSR over the real bits only
    always_ff @(posedge clk12_i) begin
        if (!rstN_i || clear_i) begin
            // Preset to all ones
            crcReg <= '1;
        end else if (bitValid_i) begin
            if (use16_i) begin
                crcReg <= {crcReg[14:0], 1'b0} ^ (feedback ? CRC16_POLY : 16'h0000);
            end else begin
                crcReg[4:0] <= {crcReg[3:0], 1'b0} ^ (feedback ? CRC5_POLY : 5'b00000);
            end
        end
    end

    // Residual match once the CRC field itself went through
    assign crcGood_o = use16_i ? (crcReg == CRC16_RESIDUAL)
                               : (crcReg[4:0] == CRC5_RESIDUAL);

endmodule

//--- verilog/packetControl.sv
`timescale 1ns/1ns

module packetControl import usbRxPkg::*; (
    input  logic    clk12_i,
    input  logic    rstN_i,
    input  logic    eop_i,
    input  rxWord_t word_i,
    input  logic    wordStrobe_i,
    input  logic    syncSeen_i,
    input  logic    stuffError_i,
    input  logic    lineError_i,
    input  logic    crcGood_i,
    output logic    hunt_o,
    output logic    restart_o,
    output logic    clearShift_o,
    output logic    crcClear_o,
    output logic    crcUse16_o,
    output logic    pushByte_o,
    output logic    packetEnd_o,
    output logic    packetBad_o,
    output logic    isDataPkt_o
);

    typedef enum logic [1:0] {
        WAIT_SYNC,
        GET_PID,
        WAIT_EOP,
        RST_PHASE
    } rxState_e;

    rxState_e state;
    // EOP delayed to line up with the decoded bit stream
    logic eopDly;
    // CRC verdict after the last completed byte
    logic crcOk;
    logic isData;
    logic pidOk;
    logic pidIsData;
    logic active;
    logic lineFault;
    logic crcFinal;

    // ========================================================================
    // PID decode and error sources
    // ========================================================================

    // Check nibble must be the complement of the type nibble
    assign pidOk = (word_i.data.pid.check == ~word_i.data.pid.pidType);
    assign pidIsData = (pktKind_e'(word_i.data.pid.pidType[1:0]) == KIND_DATA);

    // Errors count from the sync match on
    assign active = (state == GET_PID) || (state == WAIT_EOP) || syncSeen_i;
    // The EOP sample itself decodes as an invalid pair, so it is masked
    assign lineFault = active && !eopDly && (stuffError_i || lineError_i);

    // Last byte's verdict arrives together with the delayed EOP
    assign crcFinal = (wordStrobe_i && !word_i.isPid) ? crcGood_i : crcOk;

    // ========================================================================
    // Stage controls
    // ========================================================================

    assign hunt_o = (state == WAIT_SYNC);
    assign restart_o = (state == RST_PHASE);
    assign clearShift_o = (state == RST_PHASE);

    // CRC held at preset until the PID byte completes
    assign crcClear_o = (state == WAIT_SYNC) || ((state == GET_PID) && !wordStrobe_i);
    // First data bit runs with the PID just strobed
    assign crcUse16_o = (state == GET_PID) ? pidIsData : isData;

    assign pushByte_o = wordStrobe_i && ((state == GET_PID) || (state == WAIT_EOP));
    assign packetEnd_o = (state == RST_PHASE);
    assign isDataPkt_o = isData;

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            state <= WAIT_SYNC;
            eopDly <= 1'b0;
            crcOk <= 1'b1;
            isData <= 1'b0;
            packetBad_o <= 1'b0;
        end else begin
            eopDly <= eop_i;
            if (lineFault) begin
                packetBad_o <= 1'b1;
            end
            case (state)
                WAIT_SYNC: begin
                    if (syncSeen_i) begin
                        // New packet, old verdict goes away
                        packetBad_o <= lineFault;
                        state <= GET_PID;
                    end
                end
                GET_PID: begin
                    if (wordStrobe_i) begin
                        isData <= pidIsData;
                        if (!pidOk) begin
                            packetBad_o <= 1'b1;
                        end
                        // Handshake PID strobes together with the delayed EOP
                        state <= eopDly ? RST_PHASE : WAIT_EOP;
                    end else if (eopDly) begin
                        // EOP before any PID
                        packetBad_o <= 1'b1;
                        state <= RST_PHASE;
                    end
                end
                WAIT_EOP: begin
                    if (wordStrobe_i) begin
                        crcOk <= crcGood_i;
                    end
                    if (eopDly) begin
                        if (!crcFinal) begin
                            packetBad_o <= 1'b1;
                        end
                        state <= RST_PHASE;
                    end
                end
                default: begin
                    // PID-only packets carry no CRC
                    crcOk <= 1'b1;
                    state <= WAIT_SYNC;
                end
            endcase
        end
    end

endmodule

//--- verilog/byteOutput.sv
`timescale 1ns/1ns

module byteOutput import usbRxPkg::*; #(
    parameter int CREDITS = 2,
    parameter int HOLD_DEPTH = 4,
    parameter int FLUSH_TIMEOUT = 3
) (
    input  logic    clk12_i,
    input  logic    rstN_i,
    input  rxWord_t word_i,
    input  logic    pushByte_i,
    input  logic    syncSeen_i,
    input  logic    packetEnd_i,
    input  logic    packetBad_i,
    input  logic    isDataPkt_i,
    input  logic    creditReturn_i,
    output byte_t   rxData_o,
    output logic    rxValid_o,
    output logic    rxDone_o,
    output logic    rxKeep_o
);

    localparam int PW = $clog2(HOLD_DEPTH);
    localparam int CW = $clog2(HOLD_DEPTH + 1);
    localparam int KW = $clog2(CREDITS + 1);
    localparam int TW = $clog2(FLUSH_TIMEOUT + 1);

    typedef enum logic {
        FILL,
        DRAIN
    } outState_e;

    byte_t holdMem [HOLD_DEPTH];
    logic [PW-1:0] wrPtr;
    logic [PW-1:0] rdPtr;
    logic [CW-1:0] count;
    logic [KW-1:0] credit;
    logic [TW-1:0] timer;
    outState_e state;
    // A byte was dropped on a full buffer
    logic lost;
    logic holdBack;
    logic pop;
    logic accept;

    function automatic logic [PW-1:0] ptrInc(input logic [PW-1:0] ptr);
        return (ptr == PW'(HOLD_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Step back over the two newest entries
    function automatic logic [PW-1:0] ptrBack2(input logic [PW-1:0] ptr);
        return (ptr >= PW'(2)) ? ptr - PW'(2) : ptr + PW'(HOLD_DEPTH - 2);
    endfunction

    // ========================================================================
    // Release rules
    // ========================================================================

    // Data packets keep the two newest bytes back, they may be the CRC
    assign holdBack = isDataPkt_i && (count <= CW'(2));

    assign pop = (count != '0) && (credit != '0) && !packetEnd_i
               && (((state == FILL) && !holdBack) || ((state == DRAIN) && (timer != '0)));

    // A full buffer still takes a byte if one leaves in the same cycle
    assign accept = pushByte_i && ((count != CW'(HOLD_DEPTH)) || pop);

    assign rxValid_o = pop;
    assign rxData_o = holdMem[rdPtr];
    // Empty buffer or expired drain ends the packet
    assign rxDone_o = (state == DRAIN) && ((count == '0) || (timer == '0));
    assign rxKeep_o = (count == '0) && !lost && !packetBad_i;

    always_ff @(posedge clk12_i) begin
        if (accept) begin
            holdMem[wrPtr] <= word_i.data.raw;
        end
    end

    // ========================================================================
    // Pointers, credit and drain control
    // ========================================================================

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credit <= KW'(CREDITS);
            timer <= '0;
            state <= FILL;
            lost <= 1'b0;
        end else begin
            credit <= credit - KW'(pop) + KW'(creditReturn_i);
            if (syncSeen_i) begin
                lost <= 1'b0;
            end else if (pushByte_i && !accept) begin
                lost <= 1'b1;
            end
            if (pop) begin
                rdPtr <= ptrInc(rdPtr);
            end
            if (accept) begin
                wrPtr <= ptrInc(wrPtr);
            end
            count <= count + CW'(accept) - CW'(pop);
            case (state)
                FILL: begin
                    if (packetEnd_i) begin
                        timer <= TW'(FLUSH_TIMEOUT);
                        state <= DRAIN;
                        // Bad packet is thrown away whole
                        if (packetBad_i || (isDataPkt_i && (count < CW'(2)))) begin
                            wrPtr <= rdPtr;
                            count <= '0;
                        end else if (isDataPkt_i) begin
                            // Drop the CRC16 bytes
                            wrPtr <= ptrBack2(wrPtr);
                            count <= count - CW'(2);
                        end
                    end
                end
                default: begin
                    if (rxDone_o) begin
                        // On timeout whatever is left is discarded
                        wrPtr <= rdPtr;
                        count <= '0;
                        state <= FILL;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- verilog/usbRxTop.sv
`timescale 1ns/1ns

module usbRxTop import usbRxPkg::*; #(
    parameter int CREDITS = 2,
    parameter int HOLD_DEPTH = 4,
    parameter int FLUSH_TIMEOUT = 3
) (
    input  logic        clk12_i,
    input  logic        rstN_i,
    input  lineSample_t lineSample_i,
    input  logic        creditReturn_i,
    output byte_t       rxData_o,
    output logic        rxValid_o,
    output logic        rxDone_o,
    output logic        rxKeep_o
);

    // Decoded bit stream
    logic bitValid;
    logic bitData;
    logic stuffError;
    logic lineError;

    // Byte stage
    rxWord_t word;
    logic wordStrobe;
    logic syncSeen;

    // Control from the packet FSM
    logic hunt;
    logic restart;
    logic clearShift;
    logic crcClear;
    logic crcUse16;
    logic crcGood;
    logic pushByte;
    logic packetEnd;
    logic packetBad;
    logic isDataPkt;

    // ========================================================================
    // Bit level
    // ========================================================================

    nrziUnstuff nrzi (
        .clk12_i     (clk12_i),
        .rstN_i      (rstN_i),
        .sample_i    (lineSample_i),
        .restart_i   (restart),
        .bitValid_o  (bitValid),
        .bitData_o   (bitData),
        .stuffError_o(stuffError),
        .lineError_o (lineError)
    );

    byteDeserializer deser (
        .clk12_i     (clk12_i),
        .rstN_i      (rstN_i),
        .bitValid_i  (bitValid),
        .bitData_i   (bitData),
        .hunt_i      (hunt),
        .clear_i     (clearShift),
        .word_o      (word),
        .wordStrobe_o(wordStrobe),
        .syncSeen_o  (syncSeen)
    );

    crcCheck crc (
        .clk12_i   (clk12_i),
        .rstN_i    (rstN_i),
        .clear_i   (crcClear),
        .use16_i   (crcUse16),
        .bitValid_i(bitValid),
        .bitData_i (bitData),
        .crcGood_o (crcGood)
    );

    // ========================================================================
    // Packet level
    // ========================================================================

    packetControl ctrl (
        .clk12_i     (clk12_i),
        .rstN_i      (rstN_i),
        .eop_i       (lineSample_i.eop),
        .word_i      (word),
        .wordStrobe_i(wordStrobe),
        .syncSeen_i  (syncSeen),
        .stuffError_i(stuffError),
        .lineError_i (lineError),
        .crcGood_i   (crcGood),
        .hunt_o      (hunt),
        .restart_o   (restart),
        .clearShift_o(clearShift),
        .crcClear_o  (crcClear),
        .crcUse16_o  (crcUse16),
        .pushByte_o  (pushByte),
        .packetEnd_o (packetEnd),
        .packetBad_o (packetBad),
        .isDataPkt_o (isDataPkt)
    );

    byteOutput #(
        .CREDITS      (CREDITS),
        .HOLD_DEPTH   (HOLD_DEPTH),
        .FLUSH_TIMEOUT(FLUSH_TIMEOUT)
    ) out (
        .clk12_i       (clk12_i),
        .rstN_i        (rstN_i),
        .word_i        (word),
        .pushByte_i    (pushByte),
        .syncSeen_i    (syncSeen),
        .packetEnd_i   (packetEnd),
        .packetBad_i   (packetBad),
        .isDataPkt_i   (isDataPkt),
        .creditReturn_i(creditReturn_i),
        .rxData_o      (rxData_o),
        .rxValid_o     (rxValid_o),
        .rxDone_o      (rxDone_o),
        .rxKeep_o      (rxKeep_o)
    );

endmodule

//--- tests/usbRxChecker.sv
`timescale 1ns/1ns

module usbRxChecker import usbRxPkg::*; (
    input  logic  clk12_i,
    input  byte_t rxData_i,
    input  logic  rxValid_i,
    input  logic  rxDone_i,
    input  logic  rxKeep_i
);

    // Bytes still owed by the DUT for the current packet
    byte_t expQ[$];
    logic expKeep = 1'b1;
    logic compareBytes = 1'b0;
    logic pendingData = 1'b0;
    int errorCount = 0;
    int doneCount = 0;
    int byteCount = 0;

    // New packet, verdict predicted from corruption and back-pressure
    function void startPacket(input logic isData, input logic lineGood, input logic overflow);
        expQ.delete();
        pendingData = isData;
        expKeep = lineGood && !overflow;
        // Byte stream only meaningful for a kept packet
        compareBytes = expKeep;
    endfunction

    // Every byte as it goes on the wire, CRC bytes included
    function void addWireByte(input byte_t b);
        expQ.push_back(b);
    endfunction

    function void closePacket();
        // Data packets lose their two CRC16 bytes
        if (pendingData && expQ.size() >= 2) begin
            void'(expQ.pop_back());
            void'(expQ.pop_back());
        end
    endfunction

    function void reportMissingDone(input int row);
        $display("Packet %0d: rxDone_o never pulsed after EOP", row);
        errorCount++;
    endfunction

    // Sampled mid cycle, away from the clock edge
    always @(negedge clk12_i) begin
        if (rxValid_i && compareBytes) begin
            if (expQ.size() == 0) begin
                $display("At %0t the DUT delivered byte %02h beyond the end of the packet",
                         $time, rxData_i);
                errorCount++;
            end else begin
                byteCount++;
                if (rxData_i !== expQ[0]) begin
                    $display("[FAIL] %0t rxData_o expected %02h got %02h",
                             $time, expQ[0], rxData_i);
                    errorCount++;
                end
                void'(expQ.pop_front());
            end
        end
        if (rxDone_i) begin
            doneCount++;
            if (rxKeep_i !== expKeep) begin
                $display("[FAIL] %0t rxKeep_o expected %0b got %0b", $time, expKeep, rxKeep_i);
                errorCount++;
            end
            // Leftover bytes mean some never came out
            if (compareBytes && expQ.size() != 0) begin
                $display("At %0t rxDone_o came with %0d bytes not yet delivered",
                         $time, expQ.size());
                errorCount++;
            end
            compareBytes = 1'b0;
        end
    end

endmodule

//--- tests/usbRxTb.sv
`timescale 1ns/1ns

module usbRxTb import usbRxPkg::*; ();

    localparam int NUM_ROWS = 11;
    // Must match the DUT defaults
    localparam int CREDITS_INIT = 2;
    localparam int HOLD_SLOTS = 4;
    localparam int DONE_WAIT = 20;

    // Corruption kinds
    localparam int CORRUPT_NONE = 0;
    localparam int CORRUPT_CRC = 1;
    localparam int CORRUPT_PID = 2;
    localparam int CORRUPT_STUFF = 3;
    localparam int CORRUPT_LINE = 4;

    // Credit modes
    localparam int CREDIT_PROMPT = 0;
    localparam int CREDIT_RANDOM = 1;
    localparam int CREDIT_WITHHELD = 2;

    logic clk12_i;
    logic rstN_i;
    lineSample_t lineSample;
    logic creditReturn;
    byte_t rxData;
    logic rxValid;
    logic rxDone;
    logic rxKeep;

    // ========================================================================
    // Packet table
    // ========================================================================

    byte_t rowPid[NUM_ROWS];
    int rowLen[NUM_ROWS];
    // Payload, byte 0 in the low bits
    logic [63:0] rowPay[NUM_ROWS];
    int rowCorrupt[NUM_ROWS];
    int rowCredit[NUM_ROWS];

    // Encoder work queues
    logic payBits[$];
    logic dataBits[$];
    logic lineBits[$];
    byte_t wireBytes[$];

    int creditMode;
    int owed;
    int waitLeft;

    usbRxTop dut (
        .clk12_i       (clk12_i),
        .rstN_i        (rstN_i),
        .lineSample_i  (lineSample),
        .creditReturn_i(creditReturn),
        .rxData_o      (rxData),
        .rxValid_o     (rxValid),
        .rxDone_o      (rxDone),
        .rxKeep_o      (rxKeep)
    );

    usbRxChecker chk (
        .clk12_i  (clk12_i),
        .rxData_i (rxData),
        .rxValid_i(rxValid),
        .rxDone_i (rxDone),
        .rxKeep_i (rxKeep)
    );

    task automatic setRow(input int i, input byte_t pid, input int len,
                          input logic [63:0] pay, input int corrupt, input int credit);
        rowPid[i] = pid;
        rowLen[i] = len;
        rowPay[i] = pay;
        rowCorrupt[i] = corrupt;
        rowCredit[i] = credit;
    endtask

    function automatic pktKind_e kindOf(input byte_t pid);
        return pktKind_e'(pid[1:0]);
    endfunction

    // USB CRC5 over the payload bits, LSB first, preset all ones
    function automatic logic [4:0] crc5OfPayload();
        logic [4:0] crc;
        logic fb;
        crc = 5'h1F;
        foreach (payBits[i]) begin
            fb = payBits[i] ^ crc[4];
            crc = {crc[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
        end
        return crc;
    endfunction

    // USB CRC16, x^16+x^15+x^2+1
    function automatic logic [15:0] crc16OfPayload();
        logic [15:0] crc;
        logic fb;
        crc = 16'hFFFF;
        foreach (payBits[i]) begin
            fb = payBits[i] ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
        end
        return crc;
    endfunction

    // Rough line length of one row, stuffing included
    function automatic int rowCycles(input int r);
        int bits;
        bits = 16;
        if (kindOf(rowPid[r]) == KIND_TOKEN) begin
            bits = bits + 16;
        end else if (kindOf(rowPid[r]) == KIND_DATA) begin
            bits = bits + 8 * rowLen[r] + 16;
        end
        return bits + bits / 6 + 1;
    endfunction

    // ========================================================================
    // Packet builder and line encoder
    // ========================================================================

    task automatic buildPacket(input int r);
        logic [4:0] crc5;
        logic [15:0] crc16;
        byte_t pid;
        byte_t b;
        int run;
        int nBits;
        logic skipped;
        payBits.delete();
        dataBits.delete();
        lineBits.delete();
        wireBytes.delete();
        pid = rowPid[r];
        if (rowCorrupt[r] == CORRUPT_PID) begin
            pid = pid ^ 8'h10;
        end
        for (int i = 0; i < 8; i++) begin
            dataBits.push_back(pid[i]);
        end
        // Token carries 11 field bits, the CRC5 fills the rest
        nBits = (kindOf(rowPid[r]) == KIND_TOKEN) ? 11 : 8 * rowLen[r];
        if (kindOf(rowPid[r]) == KIND_HANDSHAKE) begin
            nBits = 0;
        end
        for (int i = 0; i < nBits; i++) begin
            payBits.push_back(rowPay[r][i]);
            dataBits.push_back(rowPay[r][i]);
        end
        // CRC goes out inverted, MSB first
        if (kindOf(rowPid[r]) == KIND_TOKEN) begin
            crc5 = crc5OfPayload();
            for (int i = 4; i >= 0; i--) begin
                dataBits.push_back(~crc5[i]);
            end
        end else if (kindOf(rowPid[r]) == KIND_DATA) begin
            crc16 = crc16OfPayload();
            for (int i = 15; i >= 0; i--) begin
                dataBits.push_back(~crc16[i]);
            end
        end
        if (rowCorrupt[r] == CORRUPT_CRC) begin
            dataBits[dataBits.size() - 1] = ~dataBits[dataBits.size() - 1];
        end
        for (int i = 0; i < dataBits.size() / 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                b[j] = dataBits[8 * i + j];
            end
            wireBytes.push_back(b);
        end
        // Sync, then the packet, with a zero after six ones
        run = 0;
        skipped = 1'b0;
        for (int i = 0; i < 8 + dataBits.size(); i++) begin
            b[0] = (i < 8) ? SYNC_PATTERN[i] : dataBits[i - 8];
            lineBits.push_back(b[0]);
            run = b[0] ? run + 1 : 0;
            if (run == STUFF_RUN) begin
                run = 0;
                // First stuff bit left out on purpose
                if (rowCorrupt[r] == CORRUPT_STUFF && !skipped) begin
                    skipped = 1'b1;
                end else begin
                    lineBits.push_back(1'b0);
                end
            end
        end
    endtask

    task automatic driveIdle();
        @(posedge clk12_i);
        #1;
        lineSample.dp = 1'b1;
        lineSample.valid = 1'b1;
        lineSample.eop = 1'b0;
    endtask

    // NRZI, a zero toggles the line
    task automatic sendLine(input int r);
        logic level;
        level = 1'b1;
        repeat (4) driveIdle();
        foreach (lineBits[i]) begin
            if (!lineBits[i]) begin
                level = ~level;
            end
            @(posedge clk12_i);
            #1;
            lineSample.dp = level;
            lineSample.valid = !(rowCorrupt[r] == CORRUPT_LINE && i == 20);
            lineSample.eop = 1'b0;
        end
        // SE0 for the end of packet
        @(posedge clk12_i);
        #1;
        lineSample.dp = 1'b0;
        lineSample.valid = 1'b0;
        lineSample.eop = 1'b1;
        driveIdle();
    endtask

    // ========================================================================
    // Clock, credit driver, main sequence
    // ========================================================================

    initial begin
        clk12_i = 1'b0;
        forever #5 clk12_i = ~clk12_i;
    end

    // One credit back per delivered byte
    initial begin
        logic gotByte;
        creditReturn = 1'b0;
        owed = 0;
        waitLeft = 0;
        forever begin
            // rxValid has settled by mid cycle
            @(negedge clk12_i);
            gotByte = rxValid;
            @(posedge clk12_i);
            #1;
            creditReturn = 1'b0;
            if (gotByte) begin
                owed++;
            end
            if (waitLeft > 0) begin
                waitLeft--;
            end else if (owed > 0 && creditMode != CREDIT_WITHHELD) begin
                creditReturn = 1'b1;
                owed--;
                waitLeft = (creditMode == CREDIT_RANDOM) ? int'($urandom % 6) : 0;
            end
        end
    end

    initial begin
        int limit;
        int startDone;
        int waited;
        logic overflow;
        void'($urandom(64));
        rstN_i = 1'b0;
        creditMode = CREDIT_PROMPT;
        lineSample.dp = 1'b1;
        lineSample.valid = 1'b1;
        lineSample.eop = 1'b0;

        setRow(0, 8'hE1, 2, 64'h0315, CORRUPT_NONE, CREDIT_PROMPT);
        setRow(1, 8'hC3, 4, 64'h4433_2211, CORRUPT_NONE, CREDIT_PROMPT);
        setRow(2, 8'h4B, 5, 64'hA5_5AF0_0F7E, CORRUPT_NONE, CREDIT_RANDOM);
        setRow(3, 8'hD2, 0, 64'h0, CORRUPT_NONE, CREDIT_PROMPT);
        setRow(4, 8'hC3, 3, 64'hCC_BBAA, CORRUPT_CRC, CREDIT_PROMPT);
        setRow(5, 8'hE1, 2, 64'h0207, CORRUPT_PID, CREDIT_PROMPT);
        setRow(6, 8'h4B, 2, 64'hFFFF, CORRUPT_STUFF, CREDIT_PROMPT);
        setRow(7, 8'hC3, 3, 64'h12_3456, CORRUPT_LINE, CREDIT_PROMPT);
        // Longer than credit plus buffer, nothing returned
        setRow(8, 8'h4B, 8, 64'h8877_6655_4433_2211, CORRUPT_NONE, CREDIT_WITHHELD);
        setRow(9, 8'hC3, 3, 64'hEE_DDCC, CORRUPT_NONE, CREDIT_PROMPT);
        setRow(10, 8'hE1, 2, 64'h042A, CORRUPT_NONE, CREDIT_RANDOM);

        limit = 10;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + rowCycles(r) + 50;
        end
        fork
            begin
                #(limit * 10);
                $display("Watchdog expired after %0d cycles, the run is stuck", limit);
                $display("Something failed");
                $finish;
            end
        join_none

        repeat (2) @(posedge clk12_i);
        #1;
        rstN_i = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            buildPacket(r);
            overflow = (rowCredit[r] == CREDIT_WITHHELD)
                       && (wireBytes.size() > CREDITS_INIT + HOLD_SLOTS);
            chk.startPacket(kindOf(rowPid[r]) == KIND_DATA, rowCorrupt[r] == CORRUPT_NONE,
                            overflow);
            foreach (wireBytes[i]) begin
                chk.addWireByte(wireBytes[i]);
            end
            chk.closePacket();
            creditMode = rowCredit[r];
            startDone = chk.doneCount;
            sendLine(r);
            waited = 0;
            while (chk.doneCount == startDone && waited < DONE_WAIT) begin
                @(posedge clk12_i);
                waited++;
            end
            if (chk.doneCount == startDone) begin
                chk.reportMissingDone(r);
            end
            repeat (6) driveIdle();
        end

        repeat (10) @(posedge clk12_i);
        $display("Checker summary: %0d packets done, %0d bytes compared, %0d errors",
                 chk.doneCount, chk.byteCount, chk.errorCount);
        if (chk.errorCount == 0 && chk.doneCount == NUM_ROWS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/usbRxPkg.sv
verilog/nrziUnstuff.sv
verilog/byteDeserializer.sv
verilog/crcCheck.sv
verilog/packetControl.sv
verilog/byteOutput.sv
verilog/usbRxTop.sv
tests/usbRxChecker.sv
tests/usbRxTb.sv

//--- Makefile
TOP := usbRxTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
